/* cachePkg.sv */
// ######################################
// Shared cache types: data word, address,
// byte mask, request structs, FSM states
// ######################################

package cachePkg;

    // 32-bit data word
    typedef logic [31:0] wordT;

    // Byte address from the processor
    typedef logic [31:0] addrT;

    // One enable bit per byte lane
    typedef logic [3:0] maskT;

    // Processor request, held stable while cpuReqValid is high
    typedef struct packed {
        addrT addr;
        wordT wData;
        maskT byteMask;
        logic write;
    } cpuReqT;

    // Single-word memory transfer
    // Address is always word aligned
    typedef struct packed {
        addrT addr;
        wordT wData;
        logic write;
    } memReqT;

    // Controller states
    typedef enum logic [2:0] {
        idle,
        lookup,
        writeBack,
        refill,
        respond
    } ctrlState;

endpackage

/* cacheWay.sv */
// ######################################
// One way of the data cache: tags, valid
// and dirty bits, byte-masked data blocks
// ######################################

`timescale 1ns/1ns

module cacheWay import cachePkg::*; #(
    parameter int sets = 2,
    parameter int words = 4,
    localparam int indexBits = $clog2(sets),
    localparam int offsetBits = $clog2(words),
    localparam int tagBits = 30 - indexBits - offsetBits
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [indexBits-1:0]  set,
    input  logic [offsetBits-1:0] wordOffset,
    input  logic [tagBits-1:0]    tagIn,
    input  logic                  writeTag,
    input  logic                  validIn,
    input  logic                  dirtyIn,
    input  logic                  writeWord,
    input  wordT                  wData,
    input  maskT                  byteMask,
    output logic [tagBits-1:0]    tagOut,
    output logic                  valid,
    output logic                  dirty,
    output wordT                  rData
);

    // Block state, one entry per set
    logic [tagBits-1:0] tagMem [sets];
    logic [sets-1:0]    validMem;
    logic [sets-1:0]    dirtyMem;

    // Block data, words per set
    wordT dataMem [sets][words];

    always_ff @(posedge clk) begin
        if (reset) begin
            validMem <= '0;
            dirtyMem <= '0;
        end else if (writeTag) begin
            validMem[set] <= validIn;
            dirtyMem[set] <= dirtyIn;
        end
    end

    // Tag changes together with valid and dirty
    always_ff @(posedge clk) begin
        if (writeTag) begin
            tagMem[set] <= tagIn;
        end
    end

    // Refill drives a full mask, stores drive the request mask
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (writeWord && byteMask[lane]) begin
                dataMem[set][wordOffset][lane*8 +: 8] <= wData[lane*8 +: 8];
            end
        end
    end

    // Asynchronous read of the addressed set and word
    assign tagOut = tagMem[set];
    assign valid  = validMem[set];
    assign dirty  = dirtyMem[set];
    assign rData  = dataMem[set][wordOffset];

endmodule

/* wayMerge.sv */
// ######################################
// Way combining: tag compare, hit select,
// LRU bits and victim choice
// ######################################

`timescale 1ns/1ns

module wayMerge import cachePkg::*; #(
    parameter int sets = 2,
    parameter int words = 4,
    localparam int indexBits = $clog2(sets),
    localparam int offsetBits = $clog2(words),
    localparam int tagBits = 30 - indexBits - offsetBits
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [indexBits-1:0] set,
    input  logic [tagBits-1:0]   reqTag,
    input  logic [tagBits-1:0]   tag0,
    input  logic [tagBits-1:0]   tag1,
    input  logic                 valid0,
    input  logic                 valid1,
    input  logic                 dirty0,
    input  logic                 dirty1,
    input  wordT                 rData0,
    input  wordT                 rData1,
    input  logic                 lruTouch,
    input  logic                 touchWay,
    output logic                 hit,
    output logic                 hitWay,
    output logic                 victimWay,
    output logic                 victimDirty,
    output logic [tagBits-1:0]   victimTag,
    output wordT                 rData
);

    // Bit set means way 1 is least recently used
    logic [sets-1:0] lruBits;
    logic            hit0;
    logic            hit1;

    assign hit0   = valid0 && (tag0 == reqTag);
    assign hit1   = valid1 && (tag1 == reqTag);
    assign hit    = hit0 || hit1;
    assign hitWay = hit1;

    // Fill an empty way first, way 0 before way 1
    always_comb begin
        if (!valid0) begin
            victimWay = 1'b0;
        end else if (!valid1) begin
            victimWay = 1'b1;
        end else begin
            victimWay = lruBits[set];
        end
    end

    assign victimDirty = victimWay ? dirty1 : dirty0;
    assign victimTag   = victimWay ? tag1 : tag0;

    // On a miss the victim word is returned, which feeds write-back
    assign rData = (hit ? hitWay : victimWay) ? rData1 : rData0;

    // Touched way becomes most recently used
    always_ff @(posedge clk) begin
        if (reset) begin
            lruBits <= '0;
        end else if (lruTouch) begin
            lruBits[set] <= ~touchWay;
        end
    end

endmodule

/* cacheController.sv */
// ######################################
// Cache controller FSM: lookup, write-back,
// refill, respond and both bus handshakes
// ######################################

`timescale 1ns/1ns

module cacheController import cachePkg::*; #(
    parameter int sets = 2,
    parameter int words = 4,
    localparam int indexBits = $clog2(sets),
    localparam int offsetBits = $clog2(words),
    localparam int tagBits = 30 - indexBits - offsetBits
) (
    input  logic                  clk,
    input  logic                  reset,
    // Processor side
    input  logic                  cpuReqValid,
    input  cpuReqT                cpuReq,
    output logic                  cpuAck,
    output wordT                  cpuRData,
    // Memory side
    output logic                  memReqValid,
    output memReqT                memReq,
    input  logic                  memAck,
    input  wordT                  memRData,
    // From wayMerge
    input  logic                  hit,
    input  logic                  hitWay,
    input  logic                  victimWay,
    input  logic                  victimDirty,
    input  logic [tagBits-1:0]    victimTag,
    input  wordT                  wayRData,
    // To both ways
    output logic [indexBits-1:0]  set,
    output logic [offsetBits-1:0] wordOffset,
    output logic [tagBits-1:0]    reqTag,
    output wordT                  wayWData,
    output maskT                  wayMask,
    output logic                  writeWord0,
    output logic                  writeWord1,
    output logic                  writeTag0,
    output logic                  writeTag1,
    output logic                  validIn,
    output logic                  dirtyIn,
    // LRU update
    output logic                  lruTouch,
    output logic                  touchWay
);

    ctrlState              state;
    logic [offsetBits-1:0] wordCount;
    logic                  fillWay;
    logic                  lastWord;
    logic                  memTake;
    logic                  memFree;
    logic                  storeNow;
    logic                  fillNow;
    logic                  tagFill;
    logic                  accessWay;
    logic                  blockXfer;
    wordT                  mergedWord;

    // Address fields of the current request
    assign reqTag = cpuReq.addr[31 -: tagBits];
    assign set    = cpuReq.addr[offsetBits+2 +: indexBits];

    assign blockXfer  = (state == writeBack) || (state == refill);
    assign wordOffset = blockXfer ? wordCount : cpuReq.addr[2 +: offsetBits];
    assign lastWord   = (wordCount == offsetBits'(words - 1));

    // Ack seen for the current word, then ack released
    assign memTake = memReqValid && memAck;
    assign memFree = !memReqValid && !memAck;

    // Write-back uses the victim tag, refill the request tag
    always_comb begin
        memReq.addr  = {(state == writeBack) ? victimTag : reqTag, set, wordCount, 2'b00};
        memReq.wData = wayRData;
        memReq.write = (state == writeBack);
    end

    // Way write controls
    assign storeNow  = (state == respond) && !cpuAck && cpuReq.write;
    assign fillNow   = (state == refill) && memTake;
    assign tagFill   = fillNow && lastWord;
    assign accessWay = (state == respond) ? hitWay : fillWay;

    assign writeWord0 = (storeNow || fillNow) && !accessWay;
    assign writeWord1 = (storeNow || fillNow) && accessWay;
    assign writeTag0  = (storeNow || tagFill) && !accessWay;
    assign writeTag1  = (storeNow || tagFill) && accessWay;
    assign validIn    = storeNow || tagFill;
    assign dirtyIn    = storeNow;

    assign wayWData = (state == refill) ? memRData : cpuReq.wData;
    assign wayMask  = (state == refill) ? 4'hF : cpuReq.byteMask;

    assign lruTouch = (state == respond) && !cpuAck;
    assign touchWay = hitWay;

    // Store data merged over the cached word, lane by lane
    always_comb begin
        for (int lane = 0; lane < 4; lane++) begin
            mergedWord[lane*8 +: 8] = (cpuReq.write && cpuReq.byteMask[lane]) ?
                cpuReq.wData[lane*8 +: 8] : wayRData[lane*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if ((state == respond) && !cpuAck) begin
            cpuRData <= mergedWord;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= idle;
            cpuAck      <= 1'b0;
            memReqValid <= 1'b0;
            wordCount   <= '0;
            fillWay     <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (cpuReqValid) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (hit) begin
                        state <= respond;
                    end else begin
                        fillWay     <= victimWay;
                        wordCount   <= '0;
                        memReqValid <= 1'b1;
                        state       <= victimDirty ? writeBack : refill;
                    end
                end
                writeBack, refill: begin
                    if (memTake) begin
                        memReqValid <= 1'b0;
                    end else if (memFree) begin
                        // Word finished, move on
                        if (!lastWord) begin
                            wordCount   <= wordCount + 1'b1;
                            memReqValid <= 1'b1;
                        end else if (state == writeBack) begin
                            wordCount   <= '0;
                            memReqValid <= 1'b1;
                            state       <= refill;
                        end else begin
                            wordCount <= '0;
                            state     <= lookup;
                        end
                    end
                end
                respond: begin
                    if (!cpuAck) begin
                        cpuAck <= 1'b1;
                    end else if (!cpuReqValid) begin
                        cpuAck <= 1'b0;
                        state  <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* dataCache.sv */
// ######################################
// Two-way write-back data cache top
// ######################################

`timescale 1ns/1ns

module dataCache import cachePkg::*; #(
    parameter int sets = 2,
    parameter int words = 4,
    localparam int indexBits = $clog2(sets),
    localparam int offsetBits = $clog2(words),
    localparam int tagBits = 30 - indexBits - offsetBits
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   cpuReqValid,
    input  cpuReqT cpuReq,
    output logic   cpuAck,
    output wordT   cpuRData,
    output logic   memReqValid,
    output memReqT memReq,
    input  logic   memAck,
    input  wordT   memRData
);

    // Shared way controls
    logic [indexBits-1:0]  set;
    logic [offsetBits-1:0] wordOffset;
    logic [tagBits-1:0]    reqTag;
    wordT                  wayWData;
    maskT                  wayMask;
    logic                  writeWord0;
    logic                  writeWord1;
    logic                  writeTag0;
    logic                  writeTag1;
    logic                  validIn;
    logic                  dirtyIn;

    // Way lookup results
    logic [tagBits-1:0] tag0;
    logic [tagBits-1:0] tag1;
    logic               valid0;
    logic               valid1;
    logic               dirty0;
    logic               dirty1;
    wordT               rData0;
    wordT               rData1;

    // Merged results and LRU update
    logic               hit;
    logic               hitWay;
    logic               victimWay;
    logic               victimDirty;
    logic [tagBits-1:0] victimTag;
    wordT               wayRData;
    logic               lruTouch;
    logic               touchWay;

    cacheWay #(.sets(sets), .words(words)) way0 (
        .clk(clk), .reset(reset), .set(set), .wordOffset(wordOffset),
        .tagIn(reqTag), .writeTag(writeTag0), .validIn(validIn), .dirtyIn(dirtyIn),
        .writeWord(writeWord0), .wData(wayWData), .byteMask(wayMask),
        .tagOut(tag0), .valid(valid0), .dirty(dirty0), .rData(rData0)
    );

    cacheWay #(.sets(sets), .words(words)) way1 (
        .clk(clk), .reset(reset), .set(set), .wordOffset(wordOffset),
        .tagIn(reqTag), .writeTag(writeTag1), .validIn(validIn), .dirtyIn(dirtyIn),
        .writeWord(writeWord1), .wData(wayWData), .byteMask(wayMask),
        .tagOut(tag1), .valid(valid1), .dirty(dirty1), .rData(rData1)
    );

    wayMerge #(.sets(sets), .words(words)) merge (
        .clk(clk), .reset(reset), .set(set), .reqTag(reqTag),
        .tag0(tag0), .tag1(tag1), .valid0(valid0), .valid1(valid1),
        .dirty0(dirty0), .dirty1(dirty1), .rData0(rData0), .rData1(rData1),
        .lruTouch(lruTouch), .touchWay(touchWay), .hit(hit), .hitWay(hitWay),
        .victimWay(victimWay), .victimDirty(victimDirty), .victimTag(victimTag),
        .rData(wayRData)
    );

    cacheController #(.sets(sets), .words(words)) ctrl (
        .clk(clk), .reset(reset), .cpuReqValid(cpuReqValid), .cpuReq(cpuReq),
        .cpuAck(cpuAck), .cpuRData(cpuRData), .memReqValid(memReqValid),
        .memReq(memReq), .memAck(memAck), .memRData(memRData),
        .hit(hit), .hitWay(hitWay), .victimWay(victimWay), .victimDirty(victimDirty),
        .victimTag(victimTag), .wayRData(wayRData), .set(set), .wordOffset(wordOffset),
        .reqTag(reqTag), .wayWData(wayWData), .wayMask(wayMask),
        .writeWord0(writeWord0), .writeWord1(writeWord1),
        .writeTag0(writeTag0), .writeTag1(writeTag1),
        .validIn(validIn), .dirtyIn(dirtyIn), .lruTouch(lruTouch), .touchWay(touchWay)
    );

endmodule

/* tbMemory.sv */
// ######################################
// Backing memory model for the testbench:
// 256 words, four-phase ack, random delay
// ######################################

`timescale 1ns/1ns

module tbMemory import cachePkg::*; #(
    parameter logic [15:0] seed = 16'd37949
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   memReqValid,
    input  memReqT memReq,
    output logic   memAck,
    output wordT   memRData
);

    // Filled by the testbench top before reset ends
    wordT        store [256];
    logic [15:0] lfsrState;
    logic        busy;
    int          waitLeft;

    // Galois LFSR, one step per bit taken
    function automatic logic stepLfsr();
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        return lfsrState[0];
    endfunction

    // Ack delay of 0 to 3 cycles
    function automatic int drawDelay();
        int delay;
        delay = int'(stepLfsr());
        delay = delay * 2 + int'(stepLfsr());
        return delay;
    endfunction

    initial begin
        memAck   = 1'b0;
        memRData = '0;
        busy     = 1'b0;
        waitLeft = 0;
    end

    // Driven on the falling edge, the cache samples on the rising edge
    always @(negedge clk) begin
        if (reset) begin
            memAck    = 1'b0;
            busy      = 1'b0;
            waitLeft  = 0;
            lfsrState = seed;
        end else if (memAck) begin
            if (!memReqValid) begin
                memAck = 1'b0;
            end
        end else if (memReqValid) begin
            if (!busy) begin
                busy     = 1'b1;
                waitLeft = drawDelay();
            end
            if (waitLeft == 0) begin
                busy   = 1'b0;
                memAck = 1'b1;
                if (memReq.write) begin
                    store[memReq.addr[9:2]] = memReq.wData;
                end else begin
                    memRData = store[memReq.addr[9:2]];
                end
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

endmodule

/* tb_dataCache.sv */
// ######################################
// Testbench for the data cache: clock,
// reset, LFSR, reference model and tests
// ######################################

`timescale 1ns/1ns

module tb_dataCache import cachePkg::*;;

    localparam int sets        = 2;
    localparam int words       = 4;
    localparam int requests    = 260;
    localparam int memCycles   = 8;
    localparam int cycleLimit  = requests * (2 + 2 * words * memCycles) + 2000;
    localparam int randomCount = 200;

    logic   clk;
    logic   reset;
    logic   cpuReqValid;
    cpuReqT cpuReq;
    logic   cpuAck;
    wordT   cpuRData;
    logic   memReqValid;
    memReqT memReq;
    logic   memAck;
    wordT   memRData;

    wordT        shadow [256];
    logic [15:0] lfsrState;
    int          cycleCount = 0;
    int          ackLatency;
    int          memReqCount;
    int          memWriteCount;
    logic        reqSeen;
    int          countBefore;

    dataCache #(.sets(sets), .words(words)) u_dut (
        .clk(clk), .reset(reset), .cpuReqValid(cpuReqValid), .cpuReq(cpuReq),
        .cpuAck(cpuAck), .cpuRData(cpuRData), .memReqValid(memReqValid),
        .memReq(memReq), .memAck(memAck), .memRData(memRData)
    );

    tbMemory #(.seed(16'd37949)) memModel (
        .clk(clk), .reset(reset), .memReqValid(memReqValid), .memReq(memReq),
        .memAck(memAck), .memRData(memRData)
    );

    always #10 clk = ~clk;

    function automatic logic lfsrBit();
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        return lfsrState[0];
    endfunction

    function automatic logic [31:0] randBits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrBit()};
        end
        return value;
    endfunction

    // Initial memory word, mixes every address bit
    function automatic wordT fillPattern(int index);
        return wordT'(32'h3C00_0000 ^ (index * 32'h9E37_79B1));
    endfunction

    // Expected response: shadow word with the store bytes on top
    function automatic wordT refWord(addrT addr, logic write, wordT data, maskT mask);
        wordT merged;
        merged = shadow[addr[9:2]];
        for (int lane = 0; lane < 4; lane++) begin
            if (write && mask[lane]) begin
                merged[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s: expected %h, actual %h", testName, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One processor request over the four-phase handshake
    task automatic cacheAccess(input addrT addr, input logic write, input wordT data,
                               input maskT mask, output wordT result);
        int startCycle;
        @(negedge clk);
        cpuReq.addr     = addr;
        cpuReq.wData    = data;
        cpuReq.byteMask = mask;
        cpuReq.write    = write;
        cpuReqValid     = 1'b1;
        startCycle      = cycleCount;
        do @(negedge clk); while (!cpuAck);
        ackLatency  = cycleCount - startCycle - 1;
        result      = cpuRData;
        cpuReqValid = 1'b0;
        do @(negedge clk); while (cpuAck);
    endtask

    task automatic runAccess(input string testName, input addrT addr, input logic write,
                             input wordT data, input maskT mask);
        wordT expected;
        wordT actual;
        expected = refWord(addr, write, data, mask);
        if (write) begin
            shadow[addr[9:2]] = expected;
        end
        cacheAccess(addr, write, data, mask, actual);
        checkValue(testName, expected, actual);
    endtask

    // Memory request counting and write-back data check
    always @(negedge clk) begin
        if (reset) begin
            memReqCount   <= 0;
            memWriteCount <= 0;
            reqSeen       <= 1'b0;
        end else begin
            reqSeen <= memReqValid;
            if (memReqValid && !reqSeen) begin
                memReqCount <= memReqCount + 1;
                if (memReq.write) begin
                    memWriteCount <= memWriteCount + 1;
                end
            end
            if (memReqValid && memReq.write) begin
                checkValue("writeBackData", shadow[memReq.addr[9:2]], memReq.wData);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: no result after %0d clock cycles, a handshake hung",
                     cycleCount);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    initial begin
        clk         = 1'b1;
        reset       = 1'b1;
        cpuReqValid = 1'b0;
        cpuReq      = '0;
        lfsrState   = 16'd37949;
        for (int i = 0; i < 256; i++) begin
            memModel.store[i] = fillPattern(i);
            shadow[i]         = fillPattern(i);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Cold miss, then hits in the same block
        runAccess("coldReads", 32'h000, 1'b0, '0, '0);
        countBefore = memReqCount;
        runAccess("coldReads", 32'h004, 1'b0, '0, '0);
        checkValue("firstHitLatency", 2, ackLatency);
        runAccess("coldReads", 32'h008, 1'b0, '0, '0);
        runAccess("coldReads", 32'h00C, 1'b0, '0, '0);
        checkValue("coldReadsNoRefill", countBefore, memReqCount);

        // Every mask value, store then load
        for (int m = 0; m < 16; m++) begin
            runAccess("byteMaskStore", 32'h020 + m % 4 * 4, 1'b1, randBits(32), maskT'(m));
            runAccess("byteMaskLoad", 32'h020 + m % 4 * 4, 1'b0, '0, '0);
        end

        // A, B, A, C in set 1, so C replaces B
        runAccess("conflictEviction", 32'h050, 1'b0, '0, '0);
        runAccess("conflictEviction", 32'h090, 1'b0, '0, '0);
        runAccess("conflictEviction", 32'h050, 1'b0, '0, '0);
        runAccess("conflictEviction", 32'h0D0, 1'b0, '0, '0);
        countBefore = memReqCount;
        runAccess("conflictEviction", 32'h050, 1'b0, '0, '0);
        checkValue("conflictKeepsA", countBefore, memReqCount);
        runAccess("conflictEviction", 32'h090, 1'b0, '0, '0);
        checkValue("conflictRefillsB", countBefore + words, memReqCount);

        // Dirty block D is pushed out by E and then F
        runAccess("writeBack", 32'h110, 1'b1, randBits(32), 4'hF);
        runAccess("writeBack", 32'h114, 1'b1, randBits(32), 4'h5);
        runAccess("writeBack", 32'h11C, 1'b1, randBits(32), 4'hA);
        runAccess("writeBack", 32'h150, 1'b0, '0, '0);
        countBefore = memWriteCount;
        runAccess("writeBack", 32'h190, 1'b0, '0, '0);
        checkValue("writeBackCount", countBefore + words, memWriteCount);
        for (int w = 0; w < words; w++) begin
            checkValue("writeBackMemory", shadow[8'h44 + w], memModel.store[8'h44 + w]);
        end

        // Random loads and stores over eight blocks
        for (int n = 0; n < randomCount; n++) begin
            runAccess("randomMix", addrT'(32'h200 + (randBits(5) << 2)), randBits(1) == 1,
                      randBits(32), maskT'(randBits(4)));
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* project.f */
cachePkg.sv
cacheWay.sv
wayMerge.sv
cacheController.sv
dataCache.sv
tbMemory.sv
tb_dataCache.sv

/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dataCache
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BINARY) 2>&1 | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
